// ==== femtoPkg.sv ====
// --------------------
// Shared widths, opcodes, FSM states and decoded-instruction
// struct, imported by every design module of the core
// --------------------
`default_nettype none

package femtoPkg;

   // Data word and register index widths
   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // RV32I major opcodes, instr[6:2]
   localparam logic [4:0] OP_LOAD   = 5'b00000;
   localparam logic [4:0] OP_ALUIMM = 5'b00100;
   localparam logic [4:0] OP_AUIPC  = 5'b00101;
   localparam logic [4:0] OP_STORE  = 5'b01000;
   localparam logic [4:0] OP_ALUREG = 5'b01100;
   localparam logic [4:0] OP_LUI    = 5'b01101;
   localparam logic [4:0] OP_BRANCH = 5'b11000;
   localparam logic [4:0] OP_JALR   = 5'b11001;
   localparam logic [4:0] OP_JAL    = 5'b11011;

   // One-hot sequencer states
   typedef enum logic [4:0] {
      FETCH_INSTR     = 5'b00001,
      WAIT_INSTR      = 5'b00010,
      EXECUTE1        = 5'b00100,
      EXECUTE2        = 5'b01000,
      WAIT_ALU_OR_MEM = 5'b10000
   } cpuState;

   // Everything the stages need from the latched instruction
   typedef struct packed {
      logic                  isLoad;
      logic                  isAluImm;
      logic                  isAuipc;
      logic                  isStore;
      logic                  isAluReg;
      logic                  isLui;
      logic                  isBranch;
      logic                  isJalr;
      logic                  isJal;
      // funct3Is[n] set when funct3 == n
      logic [7:0]            funct3Is;
      logic [REG_ADDR_W-1:0] rdId;
      // instr[30], SUB and SRA select
      logic                  altOp;
      // instr[5], register form of ALU and store
      logic                  regForm;
      logic [XLEN-1:0]       uImm;
      logic [XLEN-1:0]       iImm;
      logic [XLEN-1:0]       sImm;
      logic [XLEN-1:0]       bImm;
      logic [XLEN-1:0]       jImm;
   } decodedInstr;

endpackage

`default_nettype wire

// ==== execIf.sv ====
// --------------------
// Execute-stage results, driven by executeStage and read
// by the sequencer and the memory aligner
// --------------------
`timescale 1ns/1ps
`default_nettype none

interface execIf import femtoPkg::*; #(
   parameter int ADDR_WIDTH = 24
) ();

   // ALU result register and shifter busy flag
   logic [XLEN-1:0]       aluOut;
   logic                  aluBusy;
   // Branch condition, latched in EXECUTE1
   logic                  predicate;
   // Address adders
   logic [ADDR_WIDTH-1:0] pcPlusImm;
   logic [ADDR_WIDTH-1:0] loadStoreAddr;
   logic [ADDR_WIDTH-1:0] jalrTarget;

   modport exec (output aluOut, aluBusy, predicate, pcPlusImm, loadStoreAddr, jalrTarget);
   modport user (input aluOut, aluBusy, predicate, pcPlusImm, loadStoreAddr, jalrTarget);

endinterface

`default_nettype wire

// ==== regFile.sv ====
// --------------------
// 32 x 32 register file, both reads registered
// --------------------
`timescale 1ns/1ps
`default_nettype none

module regFile import femtoPkg::*; (
   input  logic                  clk,
   input  logic                  regRead,
   input  logic [REG_ADDR_W-1:0] rs1Id,
   input  logic [REG_ADDR_W-1:0] rs2Id,
   input  logic                  writeBack,
   input  logic [REG_ADDR_W-1:0] rdId,
   input  logic [XLEN-1:0]       writeBackData,
   output logic [XLEN-1:0]       rs1,
   output logic [XLEN-1:0]       rs2
);

   logic [XLEN-1:0] regs [32];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (writeBack && rdId != '0) begin
         regs[rdId] <= writeBackData;
      end
   end

   // Index 0 forced to zero, entry 0 never holds a value
   always_ff @(posedge clk) begin
      if (regRead) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
// --------------------
// Combinational decode of the latched instruction into
// opcode flags, one-hot funct3 and the five immediates
// --------------------
`timescale 1ns/1ps
`default_nettype none

module decodeStage import femtoPkg::*; (
   input  logic [31:2]  instr,
   output decodedInstr  dec
);

   logic [4:0] opcode;

   // Bits 1:0 are always 11 in RV32I and never latched
   assign opcode = instr[6:2];

   always_comb begin
      // Major opcode classes
      dec.isLoad   = (opcode == OP_LOAD);
      dec.isAluImm = (opcode == OP_ALUIMM);
      dec.isAuipc  = (opcode == OP_AUIPC);
      dec.isStore  = (opcode == OP_STORE);
      dec.isAluReg = (opcode == OP_ALUREG);
      dec.isLui    = (opcode == OP_LUI);
      dec.isBranch = (opcode == OP_BRANCH);
      dec.isJalr   = (opcode == OP_JALR);
      dec.isJal    = (opcode == OP_JAL);

      // funct3 in one-hot form, cheaper to test downstream
      dec.funct3Is = 8'b00000001 << instr[14:12];

      dec.rdId    = instr[11:7];
      dec.altOp   = instr[30];
      dec.regForm = instr[5];

      // U-type, upper 20 bits
      dec.uImm = {instr[31:12], 12'b0};
      // I-type, sign-extended 12 bits
      dec.iImm = {{21{instr[31]}}, instr[30:20]};
      // S-type, split field
      dec.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      // B-type, even offsets only
      dec.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      // J-type, even offsets only
      dec.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
// --------------------
// ALU with one-bit serial shifter, branch comparator and the
// PC-relative and load/store address adders
// --------------------
`timescale 1ns/1ps
`default_nettype none

module executeStage import femtoPkg::*; #(
   parameter int ADDR_WIDTH = 24
) (
   input  logic                  clk,
   input  decodedInstr           dec,
   input  logic [XLEN-1:0]       rs1,
   input  logic [XLEN-1:0]       rs2,
   input  logic [ADDR_WIDTH-1:0] pc,
   input  logic                  aluStart,
   input  logic                  execLatch,
   execIf.exec                   ex
);

   logic [XLEN-1:0] aluIn1;
   logic [XLEN-1:0] aluIn2;
   logic [XLEN-1:0] aluPlus;
   logic [XLEN:0]   aluMinus;
   logic            lt;
   logic            ltu;
   logic            eq;
   logic            isShift;
   logic            predicateNext;
   logic [XLEN-1:0] pcImm;
   logic [XLEN-1:0] lsImm;
   logic [XLEN-1:0] aluReg;
   logic [4:0]      aluShamt;

   // Operand select
   // Register ALU and branches compare rs2, the rest use Iimm
   assign aluIn1 = rs1;
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2 : dec.iImm;

   // Adder shared by ADD and JALR
   assign aluPlus = aluIn1 + aluIn2;

   // Single 33-bit subtract gives SUB and every comparison
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + 33'd1;
   assign ltu      = aluMinus[XLEN];
   assign lt       = (aluIn1[XLEN-1] ^ aluIn2[XLEN-1]) ? aluIn1[XLEN-1] : aluMinus[XLEN];
   assign eq       = (aluMinus[XLEN-1:0] == '0);

   // SLL is funct3 001, SRL/SRA is 101
   assign isShift = dec.funct3Is[1] | dec.funct3Is[5];

   // ALU result register, shifted in place one bit per cycle
   always_ff @(posedge clk) begin
      if (aluStart) begin
         aluShamt <= isShift ? aluIn2[4:0] : 5'd0;
         aluReg   <= (isShift ? aluIn1 : '0) |
                     (dec.funct3Is[0] ?
                        ((dec.altOp & dec.regForm) ? aluMinus[XLEN-1:0] : aluPlus) : '0) |
                     (dec.funct3Is[2] ? {{(XLEN-1){1'b0}}, lt}  : '0) |
                     (dec.funct3Is[3] ? {{(XLEN-1){1'b0}}, ltu} : '0) |
                     (dec.funct3Is[4] ? (aluIn1 ^ aluIn2) : '0) |
                     (dec.funct3Is[6] ? (aluIn1 | aluIn2) : '0) |
                     (dec.funct3Is[7] ? (aluIn1 & aluIn2) : '0);
      end else if (aluShamt != 5'd0) begin
         aluShamt <= aluShamt - 5'd1;
         // SLL shifts left, SRA copies the sign bit, SRL shifts in zero
         aluReg   <= dec.funct3Is[1] ? (aluReg << 1) :
                     {dec.altOp & aluReg[XLEN-1], aluReg[XLEN-1:1]};
      end
   end

   assign ex.aluOut  = aluReg;
   assign ex.aluBusy = (aluShamt != 5'd0);

   // Branch condition per funct3
   assign predicateNext = (dec.funct3Is[0] &  eq)  |
                          (dec.funct3Is[1] & ~eq)  |
                          (dec.funct3Is[4] &  lt)  |
                          (dec.funct3Is[5] & ~lt)  |
                          (dec.funct3Is[6] &  ltu) |
                          (dec.funct3Is[7] & ~ltu);

   // JAL uses Jimm, AUIPC Uimm, branches Bimm
   assign pcImm = dec.isJal ? dec.jImm : (dec.isAuipc ? dec.uImm : dec.bImm);
   // Stores use the split S immediate
   assign lsImm = dec.isStore ? dec.sImm : dec.iImm;

   // Registered in EXECUTE1, consumed from EXECUTE2 on
   always_ff @(posedge clk) begin
      if (execLatch) begin
         ex.predicate     <= predicateNext;
         ex.pcPlusImm     <= pc + pcImm[ADDR_WIDTH-1:0];
         ex.loadStoreAddr <= rs1[ADDR_WIDTH-1:0] + lsImm[ADDR_WIDTH-1:0];
      end
   end

   // JALR target straight off the ALU adder
   assign ex.jalrTarget = aluPlus[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== memAlign.sv ====
// --------------------
// Byte and halfword lane handling for loads and stores,
// combinational between the bus and the core
// --------------------
`timescale 1ns/1ps
`default_nettype none

module memAlign import femtoPkg::*; #(
   parameter int ADDR_WIDTH = 24
) (
   input  decodedInstr     dec,
   input  logic [XLEN-1:0] rs2,
   input  logic [XLEN-1:0] memRdata,
   execIf.user             ex,
   output logic [XLEN-1:0] memWdata,
   output logic [3:0]      storeMask,
   output logic [XLEN-1:0] loadData
);

   logic [ADDR_WIDTH-1:0] addr;
   logic                  byteAccess;
   logic                  halfAccess;
   logic [15:0]           halfVal;
   logic [7:0]            byteVal;
   logic                  loadSign;

   assign addr = ex.loadStoreAddr;

   // funct3[1:0] gives the size, 00 byte, 01 halfword, 10 word
   assign byteAccess = dec.funct3Is[0] | dec.funct3Is[4];
   assign halfAccess = dec.funct3Is[1] | dec.funct3Is[5];

   // Load lane select from the low address bits
   assign halfVal = addr[1] ? memRdata[31:16] : memRdata[15:0];
   assign byteVal = addr[0] ? halfVal[15:8] : halfVal[7:0];

   // funct3[2] set means LBU/LHU, zero extension
   assign loadSign = ~(|dec.funct3Is[7:4]) & (byteAccess ? byteVal[7] : halfVal[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, byteVal} :
                     halfAccess ? {{16{loadSign}}, halfVal} :
                     memRdata;

   // Store data replicated so every legal lane sees the right byte
   assign memWdata[7:0]   = rs2[7:0];
   assign memWdata[15:8]  = addr[0] ? rs2[7:0] : rs2[15:8];
   assign memWdata[23:16] = addr[1] ? rs2[7:0] : rs2[23:16];
   assign memWdata[31:24] = addr[0] ? rs2[7:0] : (addr[1] ? rs2[15:8] : rs2[31:24]);

   // Byte mask walks with the offset, halfword picks low or high pair
   assign storeMask = byteAccess ? (4'b0001 << addr[1:0]) :
                      halfAccess ? (addr[1] ? 4'b1100 : 4'b0011) :
                      4'b1111;

endmodule

`default_nettype wire

// ==== sequencer.sv ====
// --------------------
// One-hot FSM with PC, instruction latch, write-back mux
// and all memory-bus strobes
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sequencer import femtoPkg::*; #(
   parameter logic [31:0] RESET_ADDR = 32'h0000_0000,
   parameter int          ADDR_WIDTH = 24
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [XLEN-1:0]       memRdata,
   input  logic                  memRbusy,
   input  logic                  memWbusy,
   input  decodedInstr           dec,
   input  logic [XLEN-1:0]       loadData,
   input  logic [3:0]            storeMask,
   execIf.user                   ex,
   output logic [31:2]           instr,
   output logic [ADDR_WIDTH-1:0] pc,
   output logic                  regRead,
   output logic [REG_ADDR_W-1:0] rs1Id,
   output logic [REG_ADDR_W-1:0] rs2Id,
   output logic                  writeBack,
   output logic [XLEN-1:0]       writeBackData,
   output logic                  aluStart,
   output logic                  execLatch,
   output logic [XLEN-1:0]       memAddr,
   output logic [3:0]            memWmask,
   output logic                  memRstrb
);

   cpuState               state;
   logic [ADDR_WIDTH-1:0] pcPlus4;
   logic                  isAlu;
   logic                  writesRd;
   logic                  waitDone;
   logic                  needToWait;
   logic                  jumpToPcPlusImm;

   assign pcPlus4  = pc + ADDR_WIDTH'(4);
   assign isAlu    = dec.isAluImm | dec.isAluReg;
   // Branch, store and SYSTEM leave the register file alone
   assign writesRd = dec.isLui | dec.isAuipc | dec.isJal | dec.isJalr | isAlu | dec.isLoad;
   assign waitDone = ~ex.aluBusy & ~memRbusy & ~memWbusy;
   assign needToWait      = dec.isLoad | dec.isStore | ex.aluBusy;
   assign jumpToPcPlusImm = dec.isJal | (dec.isBranch & ex.predicate);

   // Register reads issued as the instruction word arrives
   assign regRead = (state == WAIT_INSTR) & ~memRbusy;
   assign rs1Id   = memRdata[19:15];
   assign rs2Id   = memRdata[24:20];

   assign aluStart  = (state == EXECUTE1) & isAlu;
   assign execLatch = (state == EXECUTE1);

   // Written in EXECUTE2, then rewritten once a load or shift completes
   assign writeBack = writesRd &
                      ((state == EXECUTE2) | ((state == WAIT_ALU_OR_MEM) & waitDone));

   assign writeBackData = (dec.isLui              ? dec.uImm                 : '0) |
                          (isAlu                  ? ex.aluOut                : '0) |
                          (dec.isAuipc            ? XLEN'(ex.pcPlusImm)      : '0) |
                          (dec.isJal | dec.isJalr ? XLEN'(pcPlus4)           : '0) |
                          (dec.isLoad             ? loadData                 : '0);

   // PC during fetch, load/store address otherwise
   assign memAddr  = ((state == FETCH_INSTR) | (state == WAIT_INSTR)) ?
                     XLEN'(pc) : XLEN'(ex.loadStoreAddr);
   assign memRstrb = (state == FETCH_INSTR) | ((state == EXECUTE2) & dec.isLoad);
   assign memWmask = {4{(state == EXECUTE2) & dec.isStore}} & storeMask;

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Wait for a pending write before the first fetch
         state <= WAIT_ALU_OR_MEM;
         pc    <= RESET_ADDR[ADDR_WIDTH-1:0];
         // NOP, so the first wait-state exit writes only x0
         instr <= 30'h0000_0004;
      end else begin
         unique case (state)
            FETCH_INSTR: begin
               state <= WAIT_INSTR;
            end
            WAIT_INSTR: begin
               if (!memRbusy) begin
                  instr <= memRdata[31:2];
                  state <= EXECUTE1;
               end
            end
            EXECUTE1: begin
               state <= EXECUTE2;
            end
            EXECUTE2: begin
               pc    <= dec.isJalr ? ex.jalrTarget :
                        (jumpToPcPlusImm ? ex.pcPlusImm : pcPlus4);
               state <= needToWait ? WAIT_ALU_OR_MEM : FETCH_INSTR;
            end
            WAIT_ALU_OR_MEM: begin
               if (waitDone) begin
                  state <= FETCH_INSTR;
               end
            end
            default: begin
               state <= WAIT_ALU_OR_MEM;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== tachyonCore.sv ====
// --------------------
// Tachyon RV32I core top, stages joined to the native
// memory bus (rstrb, rbusy, wbusy, wmask)
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tachyonCore import femtoPkg::*; #(
   parameter logic [31:0] RESET_ADDR = 32'h0000_0000,
   parameter int          ADDR_WIDTH = 24
) (
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] memAddr,
   output logic [31:0] memWdata,
   output logic [3:0]  memWmask,
   input  logic [31:0] memRdata,
   output logic        memRstrb,
   input  logic        memRbusy,
   input  logic        memWbusy
);

   decodedInstr           dec;
   logic [31:2]           instr;
   logic [ADDR_WIDTH-1:0] pc;
   logic                  regRead;
   logic [REG_ADDR_W-1:0] rs1Id;
   logic [REG_ADDR_W-1:0] rs2Id;
   logic                  writeBack;
   logic [XLEN-1:0]       writeBackData;
   logic [XLEN-1:0]       rs1;
   logic [XLEN-1:0]       rs2;
   logic                  aluStart;
   logic                  execLatch;
   logic [XLEN-1:0]       loadData;
   logic [3:0]            storeMask;

   // Execute results shared by sequencer and aligner
   execIf #(.ADDR_WIDTH(ADDR_WIDTH)) exBus ();

   regFile iRegFile (
      .clk, .regRead, .rs1Id, .rs2Id, .writeBack,
      .rdId(dec.rdId), .writeBackData, .rs1, .rs2
   );

   decodeStage iDecode (.instr, .dec);

   executeStage #(.ADDR_WIDTH(ADDR_WIDTH)) iExecute (
      .clk, .dec, .rs1, .rs2, .pc, .aluStart, .execLatch, .ex(exBus)
   );

   memAlign #(.ADDR_WIDTH(ADDR_WIDTH)) iAlign (
      .dec, .rs2, .memRdata, .ex(exBus), .memWdata, .storeMask, .loadData
   );

   sequencer #(.RESET_ADDR(RESET_ADDR), .ADDR_WIDTH(ADDR_WIDTH)) iSeq (
      .clk, .reset, .memRdata, .memRbusy, .memWbusy, .dec, .loadData, .storeMask,
      .ex(exBus), .instr, .pc, .regRead, .rs1Id, .rs2Id, .writeBack, .writeBackData,
      .aluStart, .execLatch, .memAddr, .memWmask, .memRstrb
   );

endmodule

`default_nettype wire

// ==== tachyonCore_props.sv ====
// --------------------
// Bus and reset properties, bound into tachyonCore
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tachyonCore_props #(
   parameter logic [31:0] RESET_ADDR = 32'h0000_0000
) (
   input logic        clk,
   input logic        reset,
   input logic [31:0] memAddr,
   input logic [3:0]  memWmask,
   input logic        memRstrb
);

   logic seenFetch;

   // Set by the first read strobe after reset
   always_ff @(posedge clk) begin
      if (!reset) begin
         seenFetch <= 1'b0;
      end else if (memRstrb) begin
         seenFetch <= 1'b1;
      end
   end

   noReadDuringWrite: assert property (@(posedge clk) disable iff (!reset)
      !(memRstrb && (memWmask != 4'b0000)))
      else $error("read strobe and write mask active in the same cycle");

   // Byte, halfword and word patterns only
   legalMask: assert property (@(posedge clk) disable iff (!reset)
      memWmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                       4'b0011, 4'b1100, 4'b1111})
      else $error("write mask pattern is not a legal lane combination");

   firstFetchAddr: assert property (@(posedge clk) disable iff (!reset)
      (memRstrb && !seenFetch) |-> (memAddr == RESET_ADDR))
      else $error("first fetch after reset is not at the reset address");

endmodule

`default_nettype wire

// ==== tbTachyon.sv ====
// --------------------
// Directed testbench for the Tachyon core, with a bus memory
// model, hand-assembled programs and store-record checks
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tbTachyon;

   localparam int          CLK_PERIOD  = 8;
   localparam int          NUM_TESTS   = 6;
   localparam logic [31:0] RESET_ADDR  = 32'h0000_0000;
   localparam logic [31:0] RESULT_BASE = 32'h0000_0300;
   // RV32I major opcodes, full 7 bits
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_ALUIMM = 7'b0010011;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_ALUREG = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;

   logic        clk = 1'b0;
   logic        reset = 1'b0;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata = 32'h0;
   logic        memRstrb;
   logic        memRbusy = 1'b0;
   logic        memWbusy = 1'b0;

   // Program image, copied into the memory model during reset
   logic [31:0] image [256];
   logic [31:0] mem [256];
   logic [1:0]  busyTable [64];
   logic [5:0]  latIdx = 6'd0;
   logic [1:0]  busyLeft = 2'd0;
   logic [31:0] recAddr [$];
   logic [31:0] recData [$];
   logic [3:0]  recMask [$];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   logic [3:0]  expMask [$];
   int          seed = 57448;
   int          pcIdx;
   int          slot;
   int          errors = 0;
   int          checks = 0;

   tachyonCore #(.RESET_ADDR(RESET_ADDR), .ADDR_WIDTH(32)) i_dut (
      .clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata,
      .memRstrb, .memRbusy, .memWbusy
   );

   bind tachyonCore tachyonCore_props #(.RESET_ADDR(RESET_ADDR)) iProps (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWmask(memWmask), .memRstrb(memRstrb)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] laneMask(logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   // Memory model, read busy 0 to 2 cycles, write busy 1 cycle
   always @(posedge clk) begin
      if (!reset) begin
         mem      <= image;
         memRbusy <= 1'b0;
         memWbusy <= 1'b0;
         busyLeft <= 2'd0;
         recAddr.delete();
         recData.delete();
         recMask.delete();
      end else begin
         memWbusy <= 1'b0;
         if (memRstrb) begin
            memRdata <= mem[memAddr[9:2]];
            busyLeft <= busyTable[latIdx];
            memRbusy <= (busyTable[latIdx] != 2'd0);
            latIdx   <= latIdx + 6'd1;
         end else if (busyLeft != 2'd0) begin
            busyLeft <= busyLeft - 2'd1;
            memRbusy <= (busyLeft > 2'd1);
         end
         if (memWmask != 4'b0000) begin
            mem[memAddr[9:2]] <= (mem[memAddr[9:2]] & ~laneMask(memWmask)) |
                                 (memWdata & laneMask(memWmask));
            memWbusy <= 1'b1;
            recAddr.push_back(memAddr);
            recData.push_back(memWdata);
            recMask.push_back(memWmask);
         end
      end
   end

   // Instruction encoders
   function automatic logic [31:0] encR(logic [31:0] f7, logic [31:0] rs2, logic [31:0] rs1,
                                        logic [31:0] f3, logic [31:0] rd, logic [6:0] op);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
   endfunction

   function automatic logic [31:0] encI(logic [31:0] imm, logic [31:0] rs1, logic [31:0] f3,
                                        logic [31:0] rd, logic [6:0] op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
   endfunction

   function automatic logic [31:0] encS(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1,
                                        logic [31:0] f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
   endfunction

   function automatic logic [31:0] encB(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1,
                                        logic [31:0] f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encU(logic [31:0] imm, logic [31:0] rd, logic [6:0] op);
      return {imm[31:12], rd[4:0], op};
   endfunction

   function automatic logic [31:0] encJ(logic [31:0] imm, logic [31:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
   endfunction

   function automatic logic [31:0] addrNow();
      return 32'(4 * pcIdx);
   endfunction

   task automatic putWord(logic [31:0] w);
      image[pcIdx[7:0]] = w;
      pcIdx = pcIdx + 1;
   endtask

   task automatic expectWrite(logic [31:0] addr, logic [31:0] data, logic [3:0] mask);
      expAddr.push_back(addr);
      expData.push_back(data);
      expMask.push_back(mask);
   endtask

   // Always LUI plus ADDI, so code size is fixed
   task automatic loadImm(logic [31:0] rd, logic [31:0] value);
      logic [31:0] hi;
      hi = (value + 32'h800) & 32'hFFFF_F000;
      putWord(encU(hi, rd, OPC_LUI));
      putWord(encI(value - hi, rd, 0, rd, OPC_ALUIMM));
   endtask

   // SW of a register into the next result slot
   task automatic storeResult(logic [31:0] rs, logic [31:0] expected);
      logic [31:0] addr;
      addr = RESULT_BASE + 32'(4 * slot);
      putWord(encS(addr, rs, 0, 2));
      expectWrite(addr, expected, 4'b1111);
      slot = slot + 1;
   endtask

   task automatic regOp(logic [31:0] f7, logic [31:0] f3, logic [31:0] expected);
      putWord(encR(f7, 2, 1, f3, 3, OPC_ALUREG));
      storeResult(3, expected);
   endtask

   task automatic newProgram();
      for (int i = 0; i < 256; i++) begin
         image[i[7:0]] = 32'hF00D_0000 | 32'(i * 4);
      end
      expAddr.delete();
      expData.delete();
      expMask.delete();
      pcIdx = int'(RESET_ADDR >> 2);
      slot  = 0;
   endtask

   // Close with a self-jump, reset, run to the halt fetch, compare writes
   task automatic runProgram(string name);
      logic [31:0] haltAddr;
      logic [31:0] lanes;
      int          n;
      haltAddr = addrNow();
      putWord(encJ(0, 0));
      @(posedge clk);
      reset <= 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b1;
      // Bus outputs sampled mid-cycle, where they are settled
      @(negedge clk);
      while (!(memRstrb && memAddr == haltAddr)) @(negedge clk);
      checks++;
      assert (recAddr.size() == expAddr.size()) else begin
         errors++;
         $display("%s: saw %0d bus writes where %0d were expected", name,
                  recAddr.size(), expAddr.size());
      end
      n = (recAddr.size() < expAddr.size()) ? recAddr.size() : expAddr.size();
      for (int i = 0; i < n; i++) begin
         // Only the enabled lanes carry data
         lanes = laneMask(expMask[i]);
         checks++;
         assert (recAddr[i] == expAddr[i]) else begin
            errors++;
            $display("Mismatch memAddr in %s write %0d: got %h, expected %h", name, i,
                     recAddr[i], expAddr[i]);
         end
         assert (recMask[i] == expMask[i]) else begin
            errors++;
            $display("Mismatch memWmask in %s write %0d: got %h, expected %h", name, i,
                     recMask[i], expMask[i]);
         end
         assert ((recData[i] & lanes) == (expData[i] & lanes)) else begin
            errors++;
            $display("Mismatch memWdata in %s write %0d: got %h, expected %h", name, i,
                     recData[i] & lanes, expData[i] & lanes);
         end
      end
   endtask

   task automatic testAlu();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      newProgram();
      a = $random(seed);
      b = $random(seed);
      r = $random(seed);
      loadImm(1, a);
      loadImm(2, b);
      putWord(encI(r, 1, 0, 3, OPC_ALUIMM));
      storeResult(3, a + {{20{r[11]}}, r[11:0]});
      regOp(32'h20, 0, a - b);
      regOp(0, 2, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      regOp(0, 3, (a < b) ? 32'd1 : 32'd0);
      regOp(0, 4, a ^ b);
      regOp(0, 6, a | b);
      regOp(0, 7, a & b);
      runProgram("alu");
   endtask

   // SLL, SRL, SRA by register, then SRAI, all from x1
   task automatic shiftCases(logic [31:0] v, int amt);
      loadImm(2, amt);
      regOp(0, 1, v << amt);
      regOp(0, 5, v >> amt);
      regOp(32'h20, 5, $signed(v) >>> amt);
      putWord(encI(32'h400 | amt, 1, 5, 3, OPC_ALUIMM));
      storeResult(3, $signed(v) >>> amt);
   endtask

   task automatic testShifts();
      newProgram();
      // Negative operand so SRA and SRL differ
      loadImm(1, 32'h8123_4567);
      shiftCases(32'h8123_4567, 0);
      shiftCases(32'h8123_4567, 1);
      shiftCases(32'h8123_4567, 17);
      shiftCases(32'h8123_4567, 31);
      runProgram("shift");
   endtask

   function automatic logic branchTaken(int f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         0: return a == b;
         1: return a != b;
         4: return $signed(a) < $signed(b);
         5: return $signed(a) >= $signed(b);
         6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   // x4 ends at 1 only when the branch falls through
   task automatic branchPair(logic [31:0] a, logic [31:0] b);
      loadImm(1, a);
      loadImm(2, b);
      for (int f = 0; f < 8; f++) begin
         if (f != 2 && f != 3) begin
            putWord(encI(0, 0, 0, 4, OPC_ALUIMM));
            putWord(encB(8, 2, 1, f));
            putWord(encI(1, 0, 0, 4, OPC_ALUIMM));
            storeResult(4, branchTaken(f, a, b) ? 32'd0 : 32'd1);
         end
      end
   endtask

   task automatic testBranches();
      logic [31:0] base;
      newProgram();
      branchPair(32'd5, 32'd5);
      branchPair(32'hFFFF_FFFD, 32'd7);
      branchPair(32'd7, 32'hFFFF_FFFD);
      // JAL over one marker write
      putWord(encI(0, 0, 0, 6, OPC_ALUIMM));
      base = addrNow();
      putWord(encJ(8, 5));
      putWord(encI(1, 0, 0, 6, OPC_ALUIMM));
      storeResult(5, base + 32'd4);
      storeResult(6, 0);
      // JALR lands 4 past x9, skipping one marker write
      base = addrNow();
      loadImm(9, base + 32'd12);
      putWord(encI(4, 9, 0, 8, OPC_JALR));
      putWord(encI(2, 0, 0, 6, OPC_ALUIMM));
      storeResult(8, base + 32'd12);
      storeResult(6, 0);
      putWord(encU(32'hABCD_E000, 10, OPC_LUI));
      storeResult(10, 32'hABCD_E000);
      base = addrNow();
      putWord(encU(32'h1234_5000, 11, OPC_AUIPC));
      storeResult(11, base + 32'h1234_5000);
      runProgram("branch");
   endtask

   task automatic loadCase(int f3, logic [31:0] addr, logic [31:0] expected);
      putWord(encI(addr, 0, f3, 3, OPC_LOAD));
      storeResult(3, expected);
   endtask

   // LB, LBU at every byte, LH, LHU at both halves, LW
   task automatic loadWordCases(logic [31:0] addr, logic [31:0] w);
      logic [31:0] s;
      for (int off = 0; off < 4; off++) begin
         s = w >> (8 * off);
         loadCase(0, addr + 32'(off), {{24{s[7]}}, s[7:0]});
         loadCase(4, addr + 32'(off), {24'h0, s[7:0]});
         if (off == 0 || off == 2) begin
            loadCase(1, addr + 32'(off), {{16{s[15]}}, s[15:0]});
            loadCase(5, addr + 32'(off), {16'h0, s[15:0]});
         end
      end
      loadCase(2, addr, w);
   endtask

   task automatic testLoads();
      newProgram();
      image[8'd128] = 32'hF1E2_8374;
      image[8'd129] = 32'h1A7F_C35B;
      loadWordCases(32'h200, 32'hF1E2_8374);
      loadWordCases(32'h204, 32'h1A7F_C35B);
      runProgram("load");
   endtask

   task automatic testStores();
      logic [31:0] v;
      newProgram();
      v = 32'hA1B2_C3D4;
      loadImm(1, v);
      for (int k = 0; k < 4; k++) begin
         putWord(encS(32'h380 + 32'(k), 1, 0, 0));
         expectWrite(32'h380 + 32'(k), {4{v[7:0]}}, 4'b0001 << k);
      end
      putWord(encS(32'h390, 1, 0, 1));
      expectWrite(32'h390, {2{v[15:0]}}, 4'b0011);
      putWord(encS(32'h392, 1, 0, 1));
      expectWrite(32'h392, {2{v[15:0]}}, 4'b1100);
      putWord(encS(32'h3A0, 1, 0, 2));
      expectWrite(32'h3A0, v, 4'b1111);
      runProgram("store");
   endtask

   task automatic testZeroReg();
      newProgram();
      putWord(encI(32'h55, 0, 0, 0, OPC_ALUIMM));
      putWord(encU(32'hFFFF_F000, 0, OPC_LUI));
      loadImm(1, 32'h1234);
      putWord(encR(0, 1, 1, 0, 0, OPC_ALUREG));
      storeResult(0, 32'd0);
      storeResult(1, 32'h1234);
      runProgram("x0");
   endtask

   task automatic fillLatency();
      logic [31:0] r;
      for (int i = 0; i < 64; i++) begin
         r = $random(seed);
         busyTable[i[5:0]] = 2'(r % 32'd3);
      end
   endtask

   initial begin
      fillLatency();
      testAlu();
      testShifts();
      testBranches();
      testLoads();
      testStores();
      testZeroReg();
      $display("Tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // Watchdog, 2000 cycles per test
   initial begin
      #(NUM_TESTS * 2000 * CLK_PERIOD);
      $display("Watchdog expired, the programs did not reach their halt loops in time");
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
femtoPkg.sv
execIf.sv
regFile.sv
decodeStage.sv
executeStage.sv
memAlign.sv
sequencer.sv
tachyonCore.sv
tachyonCore_props.sv
tbTachyon.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the Tachyon testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tbTachyon -o simTachyon

output=$(./obj_dir/simTachyon)
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
